// ==== all.f ====
+incdir+dv
src/core_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/hazard_unit.sv
src/execute_stage.sv
src/writeback_stage.sv
src/rv_core_top.sv
dv/tb_top.sv

// ==== dv/tb_prog.svh ====
`ifndef TB_PROG_SVH
`define TB_PROG_SVH

// rv32i field packing for the formats the program uses
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, rs1, rs2);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                      input logic [6:0] op, input logic [4:0] rd, rs1);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] src, base);
  return {imm[11:5], src, base, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3,
                                      input logic [4:0] rs1, rs2);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] xorshift(input logic [31:0] seed);
  logic [31:0] x;
  x = seed;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] sext12(input logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

task automatic expect_store(input int idx, input logic [31:0] value);
  allowed[idx]  = 1'b1;
  exp_data[idx] = value;
  exp_count++;
endtask

task automatic load_program();
  logic [31:0] s, r1, r2, r3;
  logic [31:0] x1, x2, x3, x4, x5, x6;
  logic [19:0] r4;
  for (int i = 0; i < 64; i++)
  begin
    rom[i]      = NOP_INST;
    dmem[i]     = 32'hc0de_0000 | 32'(i << 2);  // word holds its own byte address
    exp_data[i] = '0;
    allowed[i]  = 1'b0;
    seen[i]     = 1'b0;
  end
  exp_count = 0;
  s  = xorshift(32'd34);
  r1 = sext12(s[11:0]);
  s  = xorshift(s);
  r2 = sext12(s[11:0]);
  s  = xorshift(s);
  r3 = sext12(s[11:0]);
  s  = xorshift(s);
  r4 = s[31:12];
  // dependent alu chain
  rom[0]  = enc_i(r1[11:0], 3'b000, 7'b0010011, 5'd1, 5'd0);
  rom[1]  = enc_i(r2[11:0], 3'b000, 7'b0010011, 5'd2, 5'd1);
  rom[2]  = enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
  rom[3]  = enc_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);
  rom[4]  = enc_r(7'h00, 3'b100, 5'd5, 5'd4, 5'd2);
  rom[5]  = enc_r(7'h00, 3'b010, 5'd6, 5'd5, 5'd3);
  rom[6]  = enc_s(12'd0, 5'd3, 5'd0);
  rom[7]  = enc_s(12'd4, 5'd4, 5'd0);
  rom[8]  = enc_s(12'd8, 5'd5, 5'd0);
  rom[9]  = enc_s(12'd12, 5'd6, 5'd0);
  rom[10] = enc_i(12'h080, 3'b010, 7'b0000011, 5'd7, 5'd0);  // load-use pair
  rom[11] = enc_r(7'h00, 3'b000, 5'd8, 5'd7, 5'd1);
  rom[12] = enc_s(12'd16, 5'd8, 5'd0);
  rom[13] = enc_i(12'h080, 3'b010, 7'b0000011, 5'd9, 5'd0);
  rom[14] = enc_b(13'd8, 3'b000, 5'd9, 5'd7);                 // taken only on the loaded value
  rom[15] = enc_s(12'h040, 5'd1, 5'd0);                       // poison
  rom[16] = enc_s(12'd20, 5'd9, 5'd0);
  rom[17] = enc_j(21'd8, 5'd11);
  rom[18] = enc_s(12'h044, 5'd1, 5'd0);                       // poison
  rom[19] = enc_s(12'd24, 5'd11, 5'd0);
  rom[20] = enc_i(r3[11:0], 3'b000, 7'b0010011, 5'd0, 5'd0);
  rom[21] = enc_s(12'd28, 5'd0, 5'd0);
  rom[22] = {r4, 5'd12, 7'b0110111};                          // lui x12
  rom[23] = enc_s(12'd32, 5'd12, 5'd0);
  rom[24] = enc_j(21'd0, 5'd0);                               // park here
  x1 = r1;
  x2 = x1 + r2;
  x3 = x1 + x2;
  x4 = x3 - x1;
  x5 = x4 ^ x2;
  x6 = ($signed(x5) < $signed(x3)) ? 32'd1 : 32'd0;
  expect_store(0, x3);
  expect_store(1, x4);
  expect_store(2, x5);
  expect_store(3, x6);
  expect_store(4, 32'hc0de_0080 + x1);
  expect_store(5, 32'hc0de_0080);
  expect_store(6, 32'd72);  // jal at 0x44 links 0x48
  expect_store(7, 32'd0);
  expect_store(8, {r4, 12'h000});
endtask

`endif

// ==== dv/tb_top.sv ====
`default_nettype none

module tb_top;
  import core_pkg::*;

  logic            CLK;
  logic            arst_n;
  logic [XLEN-1:0] imem_addr, imem_data, dmem_rdata;
  logic            dmem_valid;
  dmem_req_t       dmem_req;

  logic [XLEN-1:0] rom      [0:63];
  logic [XLEN-1:0] dmem     [0:63];
  logic [XLEN-1:0] exp_data [0:63];
  logic            allowed  [0:63];
  logic            seen     [0:63];
  logic [XLEN-1:0] last_addr;
  int              store_count;
  int              exp_count;

  `include "tb_prog.svh"

  rv_core_top dut0 (
    .CLK, .arst_n, .imem_addr, .imem_data, .dmem_valid, .dmem_req, .dmem_rdata
  );

  always #2 CLK = ~CLK;

  assign imem_data  = (imem_addr[XLEN-1:8] == '0) ? rom[imem_addr[7:2]] : NOP_INST;
  assign dmem_rdata = dmem[dmem_req.addr[7:2]];  // answers in the strobe cycle

  always @(posedge CLK)
  begin
    last_addr <= imem_addr;
    if (arst_n && dmem_valid && dmem_req.we)
    begin
      dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
      seen[dmem_req.addr[7:2]] <= 1'b1;
      store_count              <= store_count + 1;
    end
  end

  function automatic logic [XLEN-1:0] expected_word(input logic [XLEN-1:0] addr);
    return exp_data[addr[7:2]];
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "stopping at first error");
  endtask

  // reset and the first cycle after it
  a_reset_pc: assert property (@(posedge CLK)
    !(arst_n && $past(arst_n)) |-> imem_addr == RESET_PC)
    else fail_run($sformatf("ERR %0t imem_addr got %h expected %h",
                            $time, $sampled(imem_addr), RESET_PC));
  a_reset_quiet: assert property (@(posedge CLK)
    !(arst_n && $past(arst_n)) |-> !dmem_valid)
    else fail_run($sformatf("ERR %0t dmem_valid got %b expected 0",
                            $time, $sampled(dmem_valid)));

  a_pc_step: assert property (@(posedge CLK) disable iff (!arst_n)
    ($past(arst_n) && !$past(dut0.stall) && !$past(dut0.branch_taken))
      |-> imem_addr == last_addr + 32'd4)
    else fail_run($sformatf("ERR %0t imem_addr got %h expected %h",
                            $time, $sampled(imem_addr), $sampled(last_addr) + 32'd4));

  a_store_allowed: assert property (@(posedge CLK) disable iff (!arst_n)
    (dmem_valid && dmem_req.we) |-> (dmem_req.addr[XLEN-1:8] == '0 &&
                                     dmem_req.addr[1:0] == 2'b00 &&
                                     allowed[dmem_req.addr[7:2]]))
    else fail_run($sformatf("store to %h, an address the program never writes",
                            $sampled(dmem_req.addr)));
  a_store_data: assert property (@(posedge CLK) disable iff (!arst_n)
    (dmem_valid && dmem_req.we) |-> dmem_req.wdata == exp_data[dmem_req.addr[7:2]])
    else fail_run($sformatf("ERR %0t dmem_req.wdata got %h expected %h", $time,
                            $sampled(dmem_req.wdata), expected_word($sampled(dmem_req.addr))));

  initial
  begin
    int waited;
    int missing;
    CLK         = 1'b0;
    arst_n      = 1'b1;
    store_count = 0;
    load_program();
    #1 arst_n = 1'b0;
    repeat (3) @(posedge CLK);
    #1 arst_n = 1'b1;
    waited = 0;
    while (store_count < exp_count && waited < 200)
    begin
      @(negedge CLK);
      waited++;
    end
    if (store_count < exp_count)
      fail_run($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
                         waited, store_count, exp_count));
    missing = 0;
    for (int i = 0; i < 64; i++)
    begin
      if (allowed[i] && !seen[i])
        missing++;
    end
    if (missing == 0)
    begin
      $display("Testbench passed");
      $finish;
    end
    else
      fail_run($sformatf("%0d expected stores never reached data memory", missing));
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
{ verilator --binary --assert --top-module tb_top -f all.f && ./obj_dir/Vtb_top; } \
  > sim.log 2>&1 || echo "Testbench failed" >> sim.log
cat sim.log
if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0

// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [XLEN-1:0] RESET_PC = '0;
  localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;
  typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_JAL} br_e;
  typedef enum logic [1:0] {FWD_NONE, FWD_EX, FWD_MEM, FWD_WB} fwd_e;

  // all-zero value of every struct below is a bubble
  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;  // operand b from imm instead of rs2
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    wb_sel_e wb_sel;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       link;
  } id_ex_t;

  typedef struct packed {
    logic                  mem_read;
    logic                  mem_write;
    logic                  reg_write;
    wb_sel_e               wb_sel;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       alu_out;     // memory address or result to forward
    logic [XLEN-1:0]       store_data;
    logic [XLEN-1:0]       link;
  } ex_mem_t;

  typedef struct packed {
    logic                  reg_write;
    wb_sel_e               wb_sel;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       alu_out;
    logic [XLEN-1:0]       load_data;
    logic [XLEN-1:0]       link;
  } mem_wb_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            we;
  } dmem_req_t;

  // operand select shared by the branch comparator and the alu
  function automatic logic [XLEN-1:0] fwd_mux(input fwd_e            sel,
                                              input logic [XLEN-1:0] ex_val,
                                              input logic [XLEN-1:0] mem_val,
                                              input logic [XLEN-1:0] wb_val,
                                              input logic [XLEN-1:0] rf_val);
    case (sel)
      FWD_EX:  return ex_val;
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return rf_val;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== src/decode_stage.sv ====
`default_nettype none

module decode_stage (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  logic [core_pkg::XLEN-1:0]       if_inst,
  input  logic [core_pkg::XLEN-1:0]       if_pc,
  input  logic [core_pkg::XLEN-1:0]       rs1_data,
  input  logic [core_pkg::XLEN-1:0]       rs2_data,
  input  core_pkg::fwd_e                 fwd_rs1,
  input  core_pkg::fwd_e                 fwd_rs2,
  input  logic [core_pkg::XLEN-1:0]       ex_fwd,
  input  logic [core_pkg::XLEN-1:0]       mem_fwd,
  input  logic [core_pkg::XLEN-1:0]       wb_fwd,
  input  logic                           bubble,
  output logic [core_pkg::REG_ADDR_W-1:0] rs1,
  output logic [core_pkg::REG_ADDR_W-1:0] rs2,
  output core_pkg::ctrl_t                dec_ctrl,
  output core_pkg::br_e                  dec_br,
  output logic                           branch_taken,
  output logic [core_pkg::XLEN-1:0]       branch_target,
  output core_pkg::id_ex_t               id_ex
);
  import core_pkg::*;

  opcode_e               opcode;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm, cmp_a, cmp_b;

  assign opcode   = opcode_e'(if_inst[6:0]);
  assign rd       = if_inst[11:7];
  assign rs1      = if_inst[19:15];
  assign rs2      = if_inst[24:20];

  always_comb
  begin
    dec_ctrl = '0;
    dec_br   = BR_NONE;
    imm      = {{20{if_inst[31]}}, if_inst[31:20]};  // I-type
    case (opcode)
      OP:
      begin
        dec_ctrl.reg_write = 1'b1;
        case (if_inst[14:12])
          3'b000:  dec_ctrl.alu_op = if_inst[30] ? ALU_SUB : ALU_ADD;
          3'b010:  dec_ctrl.alu_op = ALU_SLT;
          3'b100:  dec_ctrl.alu_op = ALU_XOR;
          3'b110:  dec_ctrl.alu_op = ALU_OR;
          3'b111:  dec_ctrl.alu_op = ALU_AND;
          default: dec_ctrl.reg_write = 1'b0;  // shifts etc not supported
        endcase
      end
      OP_IMM:
      begin
        dec_ctrl.use_imm   = 1'b1;  // addi only
        dec_ctrl.reg_write = 1'b1;
      end
      LUI:
      begin
        dec_ctrl.alu_op    = ALU_PASS_B;
        dec_ctrl.use_imm   = 1'b1;
        dec_ctrl.reg_write = 1'b1;
        imm                = {if_inst[31:12], 12'b0};
      end
      LOAD:
      begin
        dec_ctrl.use_imm   = 1'b1;
        dec_ctrl.mem_read  = 1'b1;
        dec_ctrl.reg_write = 1'b1;
        dec_ctrl.wb_sel    = WB_MEM;
      end
      STORE:
      begin
        dec_ctrl.use_imm   = 1'b1;
        dec_ctrl.mem_write = 1'b1;
        imm                = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
      end
      BRANCH:
      begin
        if (if_inst[14:12] == 3'b000)
          dec_br = BR_EQ;
        else if (if_inst[14:12] == 3'b001)
          dec_br = BR_NE;
        imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
               if_inst[11:8], 1'b0};
      end
      JAL:
      begin
        dec_br             = BR_JAL;
        dec_ctrl.alu_op    = ALU_PASS_B;
        dec_ctrl.use_imm   = 1'b1;  // keeps rs2 out of the hazard checks
        dec_ctrl.reg_write = 1'b1;
        dec_ctrl.wb_sel    = WB_LINK;
        imm = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20],
               if_inst[30:21], 1'b0};
      end
      default: ;
    endcase
    dec_ctrl.reg_write = dec_ctrl.reg_write && (rd != '0);  // x0 writes dropped here
  end

  // branch resolves here on forwarded operands
  assign cmp_a         = fwd_mux(fwd_rs1, ex_fwd, mem_fwd, wb_fwd, rs1_data);
  assign cmp_b         = fwd_mux(fwd_rs2, ex_fwd, mem_fwd, wb_fwd, rs2_data);
  assign branch_target = if_pc + imm;
  assign branch_taken  = !bubble && ((dec_br == BR_JAL) ||
                                     (dec_br == BR_EQ && cmp_a == cmp_b) ||
                                     (dec_br == BR_NE && cmp_a != cmp_b));

  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
      id_ex <= '0;
    else if (bubble)
      id_ex.ctrl <= '0;  // payload left stale
    else
    begin
      id_ex.ctrl     <= dec_ctrl;
      id_ex.rd       <= rd;
      id_ex.rs1      <= rs1;
      id_ex.rs2      <= rs2;
      id_ex.rs1_data <= rs1_data;
      id_ex.rs2_data <= rs2_data;
      id_ex.imm      <= imm;
      id_ex.link     <= if_pc + XLEN'(4);
    end
  end

  // no compressed instructions, so every redirect lands on a word
  a_target_aligned: assert property (@(posedge CLK) disable iff (!arst_n)
    branch_taken |-> branch_target[1:0] == 2'b00)
    else $error("branch or jal target not word aligned");

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`default_nettype none

module execute_stage (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  core_pkg::id_ex_t         id_ex,
  input  core_pkg::fwd_e           ex_fwd_rs1,
  input  core_pkg::fwd_e           ex_fwd_rs2,
  input  logic [core_pkg::XLEN-1:0] mem_fwd,
  input  logic [core_pkg::XLEN-1:0] wb_fwd,
  output logic [core_pkg::XLEN-1:0] ex_result,
  output core_pkg::ex_mem_t        ex_mem,
  output logic                     dmem_valid,
  output core_pkg::dmem_req_t      dmem_req
);
  import core_pkg::*;

  logic [XLEN-1:0] op_a, rs2_val, op_b, alu_out;

  assign op_a    = fwd_mux(ex_fwd_rs1, '0, mem_fwd, wb_fwd, id_ex.rs1_data);
  assign rs2_val = fwd_mux(ex_fwd_rs2, '0, mem_fwd, wb_fwd, id_ex.rs2_data);
  assign op_b    = id_ex.ctrl.use_imm ? id_ex.imm : rs2_val;

  always_comb
  begin
    case (id_ex.ctrl.alu_op)
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = op_a + op_b;
    endcase
  end

  // jal carries its link here so the later forwarding paths need no select
  assign ex_result = (id_ex.ctrl.wb_sel == WB_LINK) ? id_ex.link : alu_out;

  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
      ex_mem <= '0;
    else
    begin
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.wb_sel     <= id_ex.ctrl.wb_sel;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.alu_out    <= ex_result;
      ex_mem.store_data <= rs2_val;  // forwarded rs2 for sw
      ex_mem.link       <= id_ex.link;
    end
  end

  assign dmem_valid = ex_mem.mem_read || ex_mem.mem_write;  // one strobe per access
  assign dmem_req   = '{addr: ex_mem.alu_out, wdata: ex_mem.store_data, we: ex_mem.mem_write};

  // lw and sw move whole words only
  a_word_access: assert property (@(posedge CLK) disable iff (!arst_n)
    dmem_valid |-> dmem_req.addr[1:0] == 2'b00)
    else $error("misaligned data memory access");

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
`default_nettype none

module fetch_stage (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  logic                     stall,
  input  logic                     redirect,
  input  logic [core_pkg::XLEN-1:0] redirect_pc,
  output logic [core_pkg::XLEN-1:0] imem_addr,
  input  logic [core_pkg::XLEN-1:0] imem_data,
  output logic [core_pkg::XLEN-1:0] if_inst,
  output logic [core_pkg::XLEN-1:0] if_pc
);
  import core_pkg::*;

  logic [XLEN-1:0] pc;

  assign imem_addr = pc;  // combinational imem, data returns this cycle

  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc      <= RESET_PC;
      if_inst <= NOP_INST;
      if_pc   <= RESET_PC;
    end
    else if (!stall)
    begin
      if_pc <= pc;
      if (redirect)
      begin
        pc      <= redirect_pc;
        if_inst <= NOP_INST;  // squash the slot fetched behind the branch
      end
      else
      begin
        pc      <= pc + XLEN'(4);
        if_inst <= imem_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/hazard_unit.sv ====
`default_nettype none

module hazard_unit (
  input  logic [core_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [core_pkg::REG_ADDR_W-1:0] rs2,
  input  core_pkg::ctrl_t                dec_ctrl,
  input  core_pkg::br_e                  dec_br,
  input  core_pkg::id_ex_t               id_ex,
  input  core_pkg::ex_mem_t              ex_mem,
  input  core_pkg::mem_wb_t              mem_wb,
  output logic                           stall_load_use,
  output logic                           stall_load_branch,
  output core_pkg::fwd_e                 id_fwd_rs1,
  output core_pkg::fwd_e                 id_fwd_rs2,
  output core_pkg::fwd_e                 ex_fwd_rs1,
  output core_pkg::fwd_e                 ex_fwd_rs2
);
  import core_pkg::*;

  logic is_branch, use_rs1, use_rs2;
  logic ld_ex_hit, ld_mem_hit;

  function automatic logic hit(input logic                  wr,
                               input logic [REG_ADDR_W-1:0] rd,
                               input logic [REG_ADDR_W-1:0] src);
    return wr && (rd != '0) && (rd == src);
  endfunction

  // newest producer wins
  function automatic fwd_e pick(input logic from_ex, input logic from_mem, input logic from_wb);
    if (from_ex)
      return FWD_EX;
    else if (from_mem)
      return FWD_MEM;
    else if (from_wb)
      return FWD_WB;
    return FWD_NONE;
  endfunction

  assign is_branch = (dec_br == BR_EQ) || (dec_br == BR_NE);
  assign use_rs1   = dec_ctrl.alu_op != ALU_PASS_B;  // lui and jal have no rs1
  assign use_rs2   = !dec_ctrl.use_imm || dec_ctrl.mem_write || is_branch;

  assign ld_ex_hit = id_ex.ctrl.mem_read &&
                     ((use_rs1 && hit(id_ex.ctrl.reg_write, id_ex.rd, rs1)) ||
                      (use_rs2 && hit(id_ex.ctrl.reg_write, id_ex.rd, rs2)));
  assign ld_mem_hit = ex_mem.mem_read &&
                      (hit(ex_mem.reg_write, ex_mem.rd, rs1) ||
                       hit(ex_mem.reg_write, ex_mem.rd, rs2));

  // a branch waits until the load data sits in MEM/WB
  assign stall_load_use    = !is_branch && ld_ex_hit;
  assign stall_load_branch = is_branch && (ld_ex_hit || ld_mem_hit);

  assign id_fwd_rs1 = pick(hit(id_ex.ctrl.reg_write, id_ex.rd, rs1),
                           hit(ex_mem.reg_write, ex_mem.rd, rs1),
                           hit(mem_wb.reg_write, mem_wb.rd, rs1));
  assign id_fwd_rs2 = pick(hit(id_ex.ctrl.reg_write, id_ex.rd, rs2),
                           hit(ex_mem.reg_write, ex_mem.rd, rs2),
                           hit(mem_wb.reg_write, mem_wb.rd, rs2));
  assign ex_fwd_rs1 = pick(1'b0, hit(ex_mem.reg_write, ex_mem.rd, id_ex.rs1),
                           hit(mem_wb.reg_write, mem_wb.rd, id_ex.rs1));
  assign ex_fwd_rs2 = pick(1'b0, hit(ex_mem.reg_write, ex_mem.rd, id_ex.rs2),
                           hit(mem_wb.reg_write, mem_wb.rd, id_ex.rs2));

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`default_nettype none

module reg_file (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  logic [core_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [core_pkg::REG_ADDR_W-1:0] rs2,
  output logic [core_pkg::XLEN-1:0]       rs1_data,
  output logic [core_pkg::XLEN-1:0]       rs2_data,
  input  logic                           wb_en,
  input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
  input  logic [core_pkg::XLEN-1:0]       wb_data
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [1:31];  // x0 has no storage

  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
    if (addr == '0)
      return '0;
    else if (wb_en && wb_rd == addr)
      return wb_data;  // same-cycle write is visible
    else
      return regs[addr];
  endfunction

  always_comb
  begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  always_ff @(posedge CLK)
  begin
    if (wb_en && wb_rd != '0)
      regs[wb_rd] <= wb_data;
  end

  // decode clears reg_write for rd == x0, so no write to x0 gets this far
  a_no_x0_write: assert property (@(posedge CLK) disable iff (!arst_n)
    wb_en |-> wb_rd != '0)
    else $error("write to x0 reached the register file");

endmodule

`default_nettype wire

// ==== src/rv_core_top.sv ====
`default_nettype none

module rv_core_top (
  input  logic                     CLK,
  input  logic                     arst_n,
  output logic [core_pkg::XLEN-1:0] imem_addr,
  input  logic [core_pkg::XLEN-1:0] imem_data,
  output logic                     dmem_valid,
  output core_pkg::dmem_req_t      dmem_req,
  input  logic [core_pkg::XLEN-1:0] dmem_rdata
);
  import core_pkg::*;

  logic [XLEN-1:0]       if_inst, if_pc, rs1_data, rs2_data;
  logic [XLEN-1:0]       branch_target, ex_result, wb_data;
  logic [REG_ADDR_W-1:0] rs1, rs2, wb_rd;
  logic                  branch_taken, wb_en, stall;
  logic                  stall_load_use, stall_load_branch;
  ctrl_t                 dec_ctrl;
  br_e                   dec_br;
  id_ex_t                id_ex;
  ex_mem_t               ex_mem;
  mem_wb_t               mem_wb;
  fwd_e                  id_fwd_rs1, id_fwd_rs2, ex_fwd_rs1, ex_fwd_rs2;

  assign stall = stall_load_use || stall_load_branch;

  fetch_stage u_fetch (
    .CLK, .arst_n, .stall, .redirect(branch_taken), .redirect_pc(branch_target),
    .imem_addr, .imem_data, .if_inst, .if_pc
  );

  decode_stage u_decode (
    .CLK, .arst_n, .if_inst, .if_pc, .rs1_data, .rs2_data,
    .fwd_rs1(id_fwd_rs1), .fwd_rs2(id_fwd_rs2),
    .ex_fwd(ex_result), .mem_fwd(ex_mem.alu_out), .wb_fwd(wb_data),
    .bubble(stall), .rs1, .rs2, .dec_ctrl, .dec_br,
    .branch_taken, .branch_target, .id_ex
  );

  reg_file u_rf (
    .CLK, .arst_n, .rs1, .rs2, .rs1_data, .rs2_data, .wb_en, .wb_rd, .wb_data
  );

  hazard_unit u_hazard (
    .rs1, .rs2, .dec_ctrl, .dec_br, .id_ex, .ex_mem, .mem_wb,
    .stall_load_use, .stall_load_branch,
    .id_fwd_rs1, .id_fwd_rs2, .ex_fwd_rs1, .ex_fwd_rs2
  );

  execute_stage u_execute (
    .CLK, .arst_n, .id_ex, .ex_fwd_rs1, .ex_fwd_rs2,
    .mem_fwd(ex_mem.alu_out), .wb_fwd(wb_data),
    .ex_result, .ex_mem, .dmem_valid, .dmem_req
  );

  writeback_stage u_writeback (
    .CLK, .arst_n, .ex_mem, .dmem_rdata, .mem_wb, .wb_en, .wb_rd, .wb_data
  );

endmodule

`default_nettype wire

// ==== src/writeback_stage.sv ====
`default_nettype none

module writeback_stage (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  core_pkg::ex_mem_t              ex_mem,
  input  logic [core_pkg::XLEN-1:0]       dmem_rdata,
  output core_pkg::mem_wb_t              mem_wb,
  output logic                           wb_en,
  output logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [core_pkg::XLEN-1:0]       wb_data
);
  import core_pkg::*;

  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
      mem_wb <= '0;
    else
    begin
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.wb_sel    <= ex_mem.wb_sel;
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.alu_out   <= ex_mem.alu_out;
      mem_wb.load_data <= dmem_rdata;  // valid in the strobe cycle only
      mem_wb.link      <= ex_mem.link;
    end
  end

  assign wb_en = mem_wb.reg_write;
  assign wb_rd = mem_wb.rd;

  always_comb
  begin
    case (mem_wb.wb_sel)
      WB_MEM:  wb_data = mem_wb.load_data;
      WB_LINK: wb_data = mem_wb.link;
      default: wb_data = mem_wb.alu_out;
    endcase
  end

endmodule

`default_nettype wire
